// ==== src/cache_pkg.sv ====
package cache_pkg;

   // data side geometry
   localparam int addr_w = 16;
   localparam int data_w = 32;
   localparam int nbytes = 4;
   localparam int n_ways = 2;
   localparam int idx_w  = 4;
   localparam int n_sets = 16;
   localparam int tag_w  = 10;
   localparam int off_w  = addr_w - tag_w - idx_w;

   // control register bank
   localparam int reg_w = 2;
   localparam int cnt_w = 16;

   localparam logic [reg_w-1:0] reg_hits   = 2'd0;
   localparam logic [reg_w-1:0] reg_misses = 2'd1;
   localparam logic [reg_w-1:0] reg_inval  = 2'd2;

   // back end FSM states
   localparam logic [1:0] st_idle   = 2'd0;
   localparam logic [1:0] st_lookup = 2'd1;
   localparam logic [1:0] st_mem    = 2'd2;
   localparam logic [1:0] st_done   = 2'd3;

   // requester address whose msb picks cache or register bank
   typedef union packed {
      struct packed {
         logic             ctrl_sel;
         logic [tag_w-1:0] tag;
         logic [idx_w-1:0] index;
         logic [off_w-1:0] offset;
      } data;
      struct packed {
         logic                    ctrl_sel;
         logic [addr_w-reg_w-1:0] unused;
         logic [reg_w-1:0]        reg_sel;
      } ctrl;
   } cache_addr_t;

endpackage

// ==== src/cache_way_if.sv ====
`timescale 1ns/1ps

interface cache_way_if
   import cache_pkg::*;
();

   // lookup side, driven from the live request
   logic                           lookup;
   logic [idx_w-1:0]               index;
   logic [tag_w-1:0]               tag;
   logic [data_w-1:0]              wdata;
   logic [nbytes-1:0]              wstrb;

   // per-way write controls from the back end
   logic [n_ways-1:0]              fill_en;
   logic [n_ways-1:0]              update_en;
   logic [data_w-1:0]              fill_data;
   logic                           inval;

   // each way owns one bit and one word here
   logic [n_ways-1:0]              hit;
   logic [n_ways-1:0][data_w-1:0]  way_rdata;

   modport front (output lookup, index, tag, wdata, wstrb);

   modport way (
      input  lookup, index, tag, wdata, wstrb,
      input  fill_en, update_en, fill_data, inval,
      output hit, way_rdata
   );

   modport back (
      input  hit, way_rdata, wdata, wstrb,
      output fill_en, update_en, fill_data, inval
   );

endinterface

// ==== src/cache_front_end.sv ====
`timescale 1ns/1ps

module cache_front_end
   import cache_pkg::*;
(
   input  logic              clk_i,
   input  logic              reset,
   input  logic              req,
   input  cache_addr_t       addr,
   input  logic [data_w-1:0] wdata,
   input  logic [nbytes-1:0] wstrb,
   input  logic              data_done,
   input  logic              ctrl_ack,
   input  logic [data_w-1:0] ctrl_rdata,
   input  logic [data_w-1:0] data_rdata,
   output logic              ack,
   output logic [data_w-1:0] rdata,
   cache_way_if.front        bus,
   output logic              data_req_reg,
   output logic [addr_w-1:0] data_addr_reg,
   output logic              is_write_reg,
   output logic              ctrl_req,
   output logic [reg_w-1:0]  ctrl_reg_sel,
   output logic              ctrl_write
);

   logic busy;
   logic start;

   // only the first cycle of a held req starts anything
   assign start = req && !busy;

   // lookup runs straight off the requester's address
   assign bus.lookup = start && !addr.data.ctrl_sel;
   assign bus.index  = addr.data.index;
   assign bus.tag    = addr.data.tag;
   assign bus.wdata  = wdata;
   assign bus.wstrb  = wstrb;

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         busy         <= 1'b0;
         data_req_reg <= 1'b0;
         ctrl_req     <= 1'b0;
      end else begin
         data_req_reg <= start && !addr.data.ctrl_sel;
         ctrl_req     <= start && addr.ctrl.ctrl_sel;
         if (start) begin
            busy <= 1'b1;
         end else if (data_done || ctrl_ack) begin
            busy <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (start) begin
         data_addr_reg <= addr[addr_w-1:0];
         is_write_reg  <= |wstrb;
         ctrl_reg_sel  <= addr.ctrl.reg_sel;
         ctrl_write    <= |wstrb;
      end
   end

   // only one side can answer at a time
   assign ack   = data_done || ctrl_ack;
   assign rdata = ctrl_ack ? ctrl_rdata : data_rdata;

   // busy keeps a register access from overlapping a lookup
   assert property (@(posedge clk_i) disable iff (reset) !(ctrl_req && bus.lookup));

endmodule

// ==== src/cache_way.sv ====
`timescale 1ns/1ps

module cache_way
   import cache_pkg::*;
#(
   parameter int way_id = 0
)
(
   input  logic clk_i,
   input  logic reset,
   cache_way_if.way bus
);

   logic [tag_w-1:0]  tag_arr [n_sets];
   logic [data_w-1:0] data_arr [n_sets];
   logic [n_sets-1:0] valid;
   logic              hit_q;
   logic [data_w-1:0] rdata_q;

   // tag and data storage
   always_ff @(posedge clk_i) begin
      if (bus.fill_en[way_id]) begin
         tag_arr[bus.index]  <= bus.tag;
         data_arr[bus.index] <= bus.fill_data;
      end else if (bus.update_en[way_id]) begin
         // write hit merges only the strobed bytes
         for (int b = 0; b < nbytes; b++) begin
            if (bus.wstrb[b]) begin
               data_arr[bus.index][8*b +: 8] <= bus.wdata[8*b +: 8];
            end
         end
      end
      if (bus.lookup) begin
         rdata_q <= data_arr[bus.index];
      end
   end

   // valid bits and the registered compare
   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         valid <= '0;
         hit_q <= 1'b0;
      end else begin
         if (bus.inval) begin
            valid <= '0;
         end else if (bus.fill_en[way_id]) begin
            valid[bus.index] <= 1'b1;
         end
         if (bus.lookup) begin
            hit_q <= valid[bus.index] && (tag_arr[bus.index] == bus.tag);
         end
      end
   end

   // hit and word stay put until the next lookup
   assign bus.hit[way_id]       = hit_q;
   assign bus.way_rdata[way_id] = rdata_q;

   // back end may only update a way that matched the tag
   assert property (@(posedge clk_i) disable iff (reset)
      bus.update_en[way_id] |-> bus.hit[way_id]);

endmodule

// ==== src/cache_back_end.sv ====
`timescale 1ns/1ps

module cache_back_end
   import cache_pkg::*;
(
   input  logic              clk_i,
   input  logic              reset,
   cache_way_if.back         bus,
   input  logic              data_req_reg,
   input  logic [addr_w-1:0] data_addr_reg,
   input  logic              is_write_reg,
   input  logic              mem_ack,
   input  logic [data_w-1:0] mem_rdata,
   input  logic              inval_cmd,
   output logic              data_done,
   output logic [data_w-1:0] data_rdata,
   output logic              mem_req,
   output logic [addr_w-1:0] mem_addr,
   output logic [data_w-1:0] mem_wdata,
   output logic [nbytes-1:0] mem_wstrb,
   output logic              hit_pulse,
   output logic              miss_pulse
);

   cache_addr_t       req_addr;
   logic [1:0]        state;
   logic [1:0]        state_nxt;
   logic [n_sets-1:0] rr;
   logic              rr_way;
   logic              any_hit;
   logic              mem_phase;
   logic              fill;
   logic [n_ways-1:0] fill_sel;
   logic [data_w-1:0] hit_word;

   assign req_addr  = {1'b0, data_addr_reg};
   assign any_hit   = |bus.hit;
   assign mem_phase = (state == st_lookup) || (state == st_mem);
   assign rr_way    = rr[req_addr.data.index];
   assign fill      = mem_phase && mem_ack && !is_write_reg;
   assign fill_sel  = n_ways'(1) << rr_way;

   // pick the word of whichever way matched
   always_comb begin
      hit_word = '0;
      for (int w = 0; w < n_ways; w++) begin
         if (bus.hit[w]) begin
            hit_word = bus.way_rdata[w];
         end
      end
   end

   // lookup state is also the first memory cycle
   always_comb begin
      state_nxt = state;
      case (state)
         st_idle: begin
            if (data_req_reg) begin
               if (is_write_reg || !any_hit) begin
                  state_nxt = st_lookup;
               end else begin
                  state_nxt = st_done;
               end
            end
         end
         st_lookup, st_mem: begin
            state_nxt = mem_ack ? st_done : st_mem;
         end
         default: begin
            state_nxt = st_idle;
         end
      endcase
   end

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         state <= st_idle;
         rr    <= '0;
      end else begin
         state <= state_nxt;
         // next miss on this set goes to the other way
         if (fill) begin
            rr[req_addr.data.index] <= !rr_way;
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (state == st_idle && data_req_reg && any_hit) begin
         data_rdata <= hit_word;
      end else if (fill) begin
         data_rdata <= mem_rdata;
      end
   end

   // word aligned memory side
   assign mem_req   = mem_phase;
   assign mem_addr  = {req_addr.data.tag, req_addr.data.index, {off_w{1'b0}}};
   assign mem_wdata = bus.wdata;
   assign mem_wstrb = is_write_reg ? bus.wstrb : '0;

   assign data_done  = (state == st_done);
   assign hit_pulse  = (state == st_idle) && data_req_reg && !is_write_reg && any_hit;
   assign miss_pulse = (state == st_idle) && data_req_reg && !is_write_reg && !any_hit;

   // way controls
   assign bus.fill_en   = fill ? fill_sel : '0;
   assign bus.update_en = (state == st_lookup && is_write_reg) ? bus.hit : '0;
   assign bus.fill_data = mem_rdata;
   assign bus.inval     = inval_cmd;

   // a fill never duplicates a tag, so ways cannot both match
   assert property (@(posedge clk_i) disable iff (reset) $onehot0(bus.hit));

endmodule

// ==== src/cache_ctrl_regs.sv ====
`timescale 1ns/1ps

module cache_ctrl_regs
   import cache_pkg::*;
(
   input  logic              clk_i,
   input  logic              reset,
   input  logic              ctrl_req,
   input  logic [reg_w-1:0]  ctrl_reg_sel,
   input  logic              ctrl_write,
   input  logic              hit_pulse,
   input  logic              miss_pulse,
   output logic              ctrl_ack,
   output logic [data_w-1:0] ctrl_rdata,
   output logic              inval_cmd
);

   logic [cnt_w-1:0] hits;
   logic [cnt_w-1:0] misses;
   logic             inval_wr;

   assign inval_wr = ctrl_req && ctrl_write && (ctrl_reg_sel == reg_inval);

   always_ff @(posedge clk_i or posedge reset) begin
      if (reset) begin
         ctrl_ack  <= 1'b0;
         inval_cmd <= 1'b0;
         hits      <= '0;
         misses    <= '0;
      end else begin
         ctrl_ack  <= ctrl_req;
         inval_cmd <= inval_wr;
         if (inval_wr) begin
            hits   <= '0;
            misses <= '0;
         end else begin
            // counters stick at all ones
            if (hit_pulse && hits != '1) begin
               hits <= hits + 1'b1;
            end
            if (miss_pulse && misses != '1) begin
               misses <= misses + 1'b1;
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (ctrl_req) begin
         case (ctrl_reg_sel)
            reg_hits:   ctrl_rdata <= ctrl_write ? '0 : data_w'(hits);
            reg_misses: ctrl_rdata <= ctrl_write ? '0 : data_w'(misses);
            default:    ctrl_rdata <= '0;
         endcase
      end
   end

endmodule

// ==== src/cache_top.sv ====
`timescale 1ns/1ps

module cache_top
   import cache_pkg::*;
(
   input  logic              clk_i,
   input  logic              reset,
   input  logic              req,
   input  logic [addr_w:0]   addr,
   input  logic [data_w-1:0] wdata,
   input  logic [nbytes-1:0] wstrb,
   output logic              ack,
   output logic [data_w-1:0] rdata,
   output logic              mem_req,
   output logic [addr_w-1:0] mem_addr,
   output logic [data_w-1:0] mem_wdata,
   output logic [nbytes-1:0] mem_wstrb,
   input  logic              mem_ack,
   input  logic [data_w-1:0] mem_rdata
);

   logic              data_req_reg;
   logic [addr_w-1:0] data_addr_reg;
   logic              is_write_reg;
   logic              data_done;
   logic [data_w-1:0] data_rdata;
   logic              ctrl_req;
   logic [reg_w-1:0]  ctrl_reg_sel;
   logic              ctrl_write;
   logic              ctrl_ack;
   logic [data_w-1:0] ctrl_rdata;
   logic              hit_pulse;
   logic              miss_pulse;
   logic              inval_cmd;

   cache_way_if way_bus ();

   cache_front_end cache_front_end_inst (
      .clk_i, .reset, .req, .addr, .wdata, .wstrb,
      .data_done, .ctrl_ack, .ctrl_rdata, .data_rdata,
      .ack, .rdata,
      .bus (way_bus.front),
      .data_req_reg, .data_addr_reg, .is_write_reg,
      .ctrl_req, .ctrl_reg_sel, .ctrl_write
   );

   for (genvar w = 0; w < n_ways; w++) begin : g_way
      cache_way #(.way_id(w)) cache_way_inst (
         .clk_i, .reset,
         .bus (way_bus.way)
      );
   end

   cache_back_end cache_back_end_inst (
      .clk_i, .reset,
      .bus (way_bus.back),
      .data_req_reg, .data_addr_reg, .is_write_reg,
      .mem_ack, .mem_rdata, .inval_cmd,
      .data_done, .data_rdata,
      .mem_req, .mem_addr, .mem_wdata, .mem_wstrb,
      .hit_pulse, .miss_pulse
   );

   cache_ctrl_regs cache_ctrl_regs_inst (
      .clk_i, .reset, .ctrl_req, .ctrl_reg_sel, .ctrl_write,
      .hit_pulse, .miss_pulse,
      .ctrl_ack, .ctrl_rdata, .inval_cmd
   );

endmodule

// ==== bench/cache_tb.sv ====
`timescale 1ns/1ps

module cache_tb
   import cache_pkg::*;
;

   // 26 operations in the stimulus below and each well under 10 cycles
   localparam int max_ops   = 26;
   localparam int cyc_limit = max_ops * 10;

   logic              clk_i;
   logic              reset;
   logic              req;
   cache_addr_t       addr;
   logic [data_w-1:0] wdata;
   logic [nbytes-1:0] wstrb;
   logic              ack;
   logic [data_w-1:0] rdata;
   logic              mem_req;
   logic [addr_w-1:0] mem_addr;
   logic [data_w-1:0] mem_wdata;
   logic [nbytes-1:0] mem_wstrb;
   logic              mem_ack;
   logic [data_w-1:0] mem_rdata;

   logic [data_w-1:0] mem [64];
   logic [data_w-1:0] ref_mem [64];
   logic              ref_valid [n_ways][n_sets];
   logic [tag_w-1:0]  ref_tag [n_ways][n_sets];
   logic              ref_rr [n_sets];
   int                ref_hits;
   int                ref_misses;

   // expectations for the operation in flight
   logic [data_w-1:0] exp_rdata;
   logic              check_rdata;
   logic              exp_miss;
   logic              exp_fast;
   logic [addr_w-1:0] exp_mem_addr;
   logic [nbytes-1:0] exp_wstrb;
   logic [data_w-1:0] exp_wdata;

   logic              req_q;
   logic              mem_seen;
   int                req_cycles;
   int                cycles;
   int                errors;
   int                ops;

   cache_top cache_top_inst (
      .clk_i, .reset, .req, .addr, .wdata, .wstrb, .ack, .rdata,
      .mem_req, .mem_addr, .mem_wdata, .mem_wstrb, .mem_ack, .mem_rdata
   );

   always #2 clk_i = ~clk_i;

   // latency and memory activity of the current request
   always @(posedge clk_i) begin
      req_q <= req;
      if (req && !req_q) begin
         req_cycles <= 1;
         mem_seen   <= mem_req;
      end else begin
         if (req) req_cycles <= req_cycles + 1;
         if (mem_req) mem_seen <= 1'b1;
      end
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles > cyc_limit) begin
         $display("timeout: run went past %0d cycles without finishing", cyc_limit);
         $display("Done: errors found");
         $finish;
      end
   end

   assert property (@(posedge clk_i) disable iff (reset)
      (ack && check_rdata) |-> rdata == exp_rdata)
      else begin
         errors++;
         $display("Error %0t rdata exp %h got %h", $time, exp_rdata, $sampled(rdata));
      end
   assert property (@(posedge clk_i) disable iff (reset) ack |-> mem_seen == exp_miss)
      else begin
         errors++;
         $display("Error %0t mem_req exp %b got %b", $time, exp_miss, $sampled(mem_seen));
      end
   assert property (@(posedge clk_i) disable iff (reset) (ack && exp_fast) |-> req_cycles == 2)
      else begin
         errors++;
         $display("Error %0t ack latency exp 2 got %0d", $time, $sampled(req_cycles));
      end
   assert property (@(posedge clk_i) disable iff (reset) mem_req |-> mem_addr == exp_mem_addr)
      else begin
         errors++;
         $display("Error %0t mem_addr exp %h got %h", $time, exp_mem_addr, $sampled(mem_addr));
      end
   assert property (@(posedge clk_i) disable iff (reset) mem_req |-> mem_wstrb == exp_wstrb)
      else begin
         errors++;
         $display("Error %0t mem_wstrb exp %b got %b", $time, exp_wstrb, $sampled(mem_wstrb));
      end
   assert property (@(posedge clk_i) disable iff (reset)
      (mem_req && exp_wstrb != '0) |-> mem_wdata == exp_wdata)
      else begin
         errors++;
         $display("Error %0t mem_wdata exp %h got %h", $time, exp_wdata, $sampled(mem_wdata));
      end
   assert property (@(posedge clk_i) disable iff (reset) ack |-> req)
      else begin
         errors++;
         $display("ack was raised with no request pending at %0t", $time);
      end

   // memory with a random answer delay
   initial begin
      int delay;
      int w;
      mem_ack   = 1'b0;
      mem_rdata = '0;
      for (int i = 0; i < 64; i++) begin
         mem[i] = 32'h5a17_0000 ^ (i * 32'h0103_0507);
      end
      forever begin
         @(negedge clk_i);
         if (mem_req) begin
            delay = $urandom_range(4, 1);
            repeat (delay - 1) @(negedge clk_i);
            w = int'(mem_addr[7:2]);
            mem_rdata = mem[w];
            for (int b = 0; b < nbytes; b++) begin
               if (mem_wstrb[b]) mem[w][8*b +: 8] = mem_wdata[8*b +: 8];
            end
            mem_ack = 1'b1;
            @(negedge clk_i);
            mem_ack = 1'b0;
         end
      end
   end

   task automatic run_access(input cache_addr_t a, input logic [data_w-1:0] d,
                             input logic [nbytes-1:0] s);
      @(negedge clk_i);
      addr  = a;
      wdata = d;
      wstrb = s;
      req   = 1'b1;
      ops++;
      do @(negedge clk_i); while (!ack);
      // keep req and the expectations through the edge that samples ack
      @(negedge clk_i);
      req = 1'b0;
   endtask

   function automatic cache_addr_t data_addr(input int tag, input int idx);
      cache_addr_t a;
      a = '0;
      a.data.tag   = tag_w'(tag);
      a.data.index = idx_w'(idx);
      return a;
   endfunction

   task automatic read_word(input int tag, input int idx);
      cache_addr_t a;
      logic        hit;
      int          w;
      a   = data_addr(tag, idx);
      w   = (tag % 4) * 16 + idx;
      hit = 1'b0;
      for (int k = 0; k < n_ways; k++) begin
         if (ref_valid[k][idx] && ref_tag[k][idx] == tag_w'(tag)) hit = 1'b1;
      end
      if (hit) begin
         ref_hits++;
      end else begin
         ref_misses++;
         ref_valid[ref_rr[idx]][idx] = 1'b1;
         ref_tag[ref_rr[idx]][idx]   = tag_w'(tag);
         ref_rr[idx] = !ref_rr[idx];
      end
      exp_rdata    = ref_mem[w];
      check_rdata  = 1'b1;
      exp_miss     = !hit;
      exp_fast     = hit;
      exp_mem_addr = a[addr_w-1:0];
      exp_wstrb    = '0;
      run_access(a, '0, '0);
   endtask

   task automatic write_word(input int tag, input int idx, input logic [nbytes-1:0] s);
      cache_addr_t       a;
      logic [data_w-1:0] d;
      int                w;
      a = data_addr(tag, idx);
      w = (tag % 4) * 16 + idx;
      d = $urandom;
      for (int b = 0; b < nbytes; b++) begin
         if (s[b]) ref_mem[w][8*b +: 8] = d[8*b +: 8];
      end
      check_rdata  = 1'b0;
      exp_miss     = 1'b1;
      exp_fast     = 1'b0;
      exp_mem_addr = a[addr_w-1:0];
      exp_wstrb    = s;
      exp_wdata    = d;
      run_access(a, d, s);
   endtask

   task automatic reg_access(input logic [reg_w-1:0] sel, input logic wr);
      cache_addr_t a;
      a = '0;
      a.ctrl.ctrl_sel = 1'b1;
      a.ctrl.reg_sel  = sel;
      exp_rdata   = (sel == reg_hits) ? ref_hits : ref_misses;
      check_rdata = !wr;
      exp_miss    = 1'b0;
      exp_fast    = 1'b1;
      if (wr && sel == reg_inval) begin
         ref_hits   = 0;
         ref_misses = 0;
         for (int k = 0; k < n_ways; k++) begin
            for (int i = 0; i < n_sets; i++) ref_valid[k][i] = 1'b0;
         end
      end
      run_access(a, 32'h1, wr ? 4'hf : 4'h0);
   endtask

   initial begin
      void'($urandom(32'h1e34));
      clk_i        = 1'b0;
      reset        = 1'b1;
      req          = 1'b0;
      addr         = '0;
      wdata        = '0;
      wstrb        = '0;
      req_q        = 1'b0;
      mem_seen     = 1'b0;
      req_cycles   = 0;
      cycles       = 0;
      errors       = 0;
      ops          = 0;
      check_rdata  = 1'b0;
      exp_miss     = 1'b0;
      exp_fast     = 1'b0;
      exp_rdata    = '0;
      exp_mem_addr = '0;
      exp_wstrb    = '0;
      exp_wdata    = '0;
      ref_hits     = 0;
      ref_misses   = 0;
      for (int i = 0; i < 64; i++) ref_mem[i] = 32'h5a17_0000 ^ (i * 32'h0103_0507);
      for (int i = 0; i < n_sets; i++) begin
         ref_rr[i] = 1'b0;
         for (int k = 0; k < n_ways; k++) begin
            ref_valid[k][i] = 1'b0;
            ref_tag[k][i]   = '0;
         end
      end
      repeat (3) @(posedge clk_i);
      @(negedge clk_i);
      reset = 1'b0;

      read_word(0, 3);
      read_word(0, 3);
      read_word(0, 5);
      read_word(0, 5);
      // write hit and then write miss with no allocation
      write_word(0, 3, 4'b0101);
      read_word(0, 3);
      write_word(3, 9, 4'b1000);
      read_word(3, 9);
      read_word(3, 9);
      // three tags sharing set 3
      read_word(1, 3);
      read_word(0, 3);
      read_word(2, 3);
      read_word(0, 3);
      read_word(1, 3);
      read_word(2, 3);
      reg_access(reg_hits, 1'b0);
      reg_access(reg_misses, 1'b0);
      reg_access(reg_inval, 1'b1);
      reg_access(reg_hits, 1'b0);
      reg_access(reg_misses, 1'b0);
      read_word(0, 3);
      read_word(0, 5);
      read_word(3, 9);
      read_word(2, 3);
      reg_access(reg_hits, 1'b0);
      reg_access(reg_misses, 1'b0);

      repeat (2) @(posedge clk_i);
      $display("%0d operations, %0d errors", ops, errors);
      if (errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

// ==== files.f ====
src/cache_pkg.sv
src/cache_way_if.sv
src/cache_front_end.sv
src/cache_way.sv
src/cache_back_end.sv
src/cache_ctrl_regs.sv
src/cache_top.sv
bench/cache_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       ?= cache_tb
RTL_TOP   ?= cache_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Done: no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
